//--- lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // LC-3b encodings for the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_op_t;

    // ADD, AND, NOT view
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;     // Also the nzp field of BR and the source of STR
        lc3b_reg    src1;     // Base register for LDR/STR
        logic       imm_flag;
        logic [4:0] imm5;     // src2 sits in the low three bits
    } reg_form_t;

    // BR, LDR, STR view
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;
        logic [8:0] offset9;  // offset6 is the low six bits
    } offset_form_t;

    typedef union packed {
        reg_form_t    reg_form;
        offset_form_t offset_form;
    } lc3b_instr;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    load_regfile;
        logic    set_cc;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        lc3b_nzp nzp;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word instruction;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_word         pc;
        lc3b_word         instruction;
        lc3b_word         src1_data;
        lc3b_word         src2_data;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_word         alu;
        lc3b_word         addr;       // Address adder result
        lc3b_word         pc;
        lc3b_word         src2_data;  // Store data
    } ex_mem_t;

    localparam lc3b_word reset_pc = 16'h0000;

endpackage : lc3b_pkg

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     resp_a,
    input  lc3b_word rdata_a,
    input  logic     branch_taken,
    input  lc3b_word branch_target,
    output logic     read_a,
    output lc3b_word address_a,
    output logic     stall_fetch,
    output if_id_t   if_out
);

    lc3b_word pc;
    lc3b_word instr_q;
    logic     active;      // Low for one cycle after reset
    logic     have_word;   // Word latched while the pipeline was held
    logic     word_ready;

    assign read_a     = active & ~have_word;
    assign address_a  = pc;
    assign word_ready = have_word | (read_a & resp_a);
    assign stall_fetch = ~word_ready;

    assign if_out.pc          = pc;
    assign if_out.instruction = have_word ? instr_q : rdata_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= reset_pc;
            active    <= 1'b0;
            have_word <= 1'b0;
        end else begin
            active <= 1'b1;
            if (word_ready && !hold) begin
                // Taken branch lands after its three slots
                pc        <= branch_taken ? branch_target : pc + 16'd2;
                have_word <= 1'b0;
            end else if (read_a && resp_a) begin
                have_word <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_a && resp_a)
            instr_q <= rdata_a;
    end

endmodule : fetch_stage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word din,
    input  lc3b_reg  src1,
    input  lc3b_reg  src2,
    output lc3b_word src1_data,
    output lc3b_word src2_data
);

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (load) begin
            regs[dest] <= din;
        end
    end

    // Write in the same cycle wins over the stored value
    assign src1_data = (load && dest == src1) ? din : regs[src1];
    assign src2_data = (load && dest == src2) ? din : regs[src2];

endmodule : reg_file

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  if_id_t   id_in,
    input  logic     wb_load,
    input  lc3b_reg  wb_dest,
    input  lc3b_word wb_data,
    output id_ex_t   id_out
);

    lc3b_instr        instr;
    lc3b_control_word ctrl;
    lc3b_reg          src2_sel;
    lc3b_word         src1_data;
    lc3b_word         src2_data;

    assign instr = id_in.instruction;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_pass;
        case (instr.reg_form.opcode)
            op_add: begin
                ctrl.alu_op       = alu_add;
                ctrl.use_imm      = instr.reg_form.imm_flag;
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            op_and: begin
                ctrl.alu_op       = alu_and;
                ctrl.use_imm      = instr.reg_form.imm_flag;
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            op_not: begin
                ctrl.alu_op       = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            op_br: begin
                ctrl.is_branch = 1'b1;
                ctrl.nzp       = instr.reg_form.dest;  // nzp 000 is the NOP
            end
            op_ldr: begin
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            op_str: begin
                ctrl.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    // STR reads its store data through the dest field
    assign src2_sel = (instr.reg_form.opcode == op_str) ? instr.reg_form.dest
                                                        : instr.reg_form.imm5[2:0];

    reg_file regs_i (
        .clk       (clk),
        .rst       (rst),
        .load      (wb_load),
        .dest      (wb_dest),
        .din       (wb_data),
        .src1      (instr.reg_form.src1),
        .src2      (src2_sel),
        .src1_data (src1_data),
        .src2_data (src2_data)
    );

    assign id_out.ctrl        = ctrl;
    assign id_out.dest        = instr.reg_form.dest;
    assign id_out.pc          = id_in.pc;
    assign id_out.instruction = id_in.instruction;
    assign id_out.src1_data   = src1_data;
    assign id_out.src2_data   = src2_data;

endmodule : decode_stage

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage import lc3b_pkg::*; (
    input  id_ex_t  ex_in,
    output ex_mem_t ex_out
);

    lc3b_instr instr;
    lc3b_word  imm5_sext;
    lc3b_word  operand_b;
    lc3b_word  alu_result;
    lc3b_word  off9_word;
    lc3b_word  off6_word;
    lc3b_word  adder_base;
    lc3b_word  adder_offset;

    assign instr = ex_in.instruction;

    assign imm5_sext = {{11{instr.reg_form.imm5[4]}}, instr.reg_form.imm5};
    assign operand_b = ex_in.ctrl.use_imm ? imm5_sext : ex_in.src2_data;

    always_comb begin
        case (ex_in.ctrl.alu_op)
            alu_add: alu_result = ex_in.src1_data + operand_b;
            alu_and: alu_result = ex_in.src1_data & operand_b;
            alu_not: alu_result = ~ex_in.src1_data;
            default: alu_result = ex_in.src1_data;
        endcase
    end

    // Word offsets, scaled to bytes
    assign off9_word = {{6{instr.offset_form.offset9[8]}}, instr.offset_form.offset9, 1'b0};
    assign off6_word = {{9{instr.offset_form.offset9[5]}}, instr.offset_form.offset9[5:0], 1'b0};

    assign adder_base   = ex_in.ctrl.is_branch ? ex_in.pc + 16'd2 : ex_in.src1_data;
    assign adder_offset = ex_in.ctrl.is_branch ? off9_word : off6_word;

    assign ex_out.ctrl      = ex_in.ctrl;
    assign ex_out.dest      = ex_in.dest;
    assign ex_out.alu       = alu_result;
    assign ex_out.addr      = adder_base + adder_offset;
    assign ex_out.pc        = ex_in.pc;
    assign ex_out.src2_data = ex_in.src2_data;

endmodule : execute_stage

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  mem_in,
    input  logic     resp_b,
    input  lc3b_word rdata_b,
    output logic     read_b,
    output logic     write_b,
    output lc3b_word address_b,
    output lc3b_word wdata_b,
    output logic     stall_mem,
    output logic     branch_taken,
    output logic     wb_load,
    output lc3b_reg  wb_dest,
    output lc3b_word wb_data
);

    lc3b_nzp cc;
    lc3b_nzp cc_next;
    logic    access;

    assign read_b    = mem_in.ctrl.mem_read;
    assign write_b   = mem_in.ctrl.mem_write;
    assign address_b = mem_in.addr;
    assign wdata_b   = mem_in.src2_data;

    assign access    = read_b | write_b;
    assign stall_mem = access & ~resp_b;

    assign wb_dest = mem_in.dest;
    assign wb_data = mem_in.ctrl.mem_read ? rdata_b : mem_in.alu;

    // A load only writes back in its resp_b cycle
    assign wb_load = mem_in.ctrl.load_regfile & (~mem_in.ctrl.mem_read | resp_b);

    always_comb begin
        if (wb_data[15])
            cc_next = 3'b100;
        else if (wb_data == '0)
            cc_next = 3'b010;
        else
            cc_next = 3'b001;
    end

    always_ff @(posedge clk) begin
        if (rst)
            cc <= 3'b010;  // All registers start at zero
        else if (wb_load && mem_in.ctrl.set_cc)
            cc <= cc_next;
    end

    assign branch_taken = mem_in.ctrl.is_branch & |(mem_in.ctrl.nzp & cc);

endmodule : mem_stage

//--- cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath import lc3b_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       resp_a,
    input  lc3b_word   rdata_a,
    output logic       read_a,
    output logic       write_a,
    output logic [1:0] wmask_a,
    output lc3b_word   address_a,
    output lc3b_word   wdata_a,

    input  logic       resp_b,
    input  lc3b_word   rdata_b,
    output logic       read_b,
    output logic       write_b,
    output logic [1:0] wmask_b,
    output lc3b_word   address_b,
    output lc3b_word   wdata_b
);

    if_id_t   if_out, if_id;
    id_ex_t   id_out, id_ex;
    ex_mem_t  ex_out, ex_mem;

    logic     stall_fetch;
    logic     stall_mem;
    logic     stall;
    logic     mem_done;
    logic     branch_taken;
    logic     wb_load;
    lc3b_reg  wb_dest;
    lc3b_word wb_data;

    assign stall = stall_fetch | stall_mem;

    // Port B finished but fetch still holds the pipeline
    assign mem_done = stall & ~stall_mem & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);

    assign write_a = 1'b0;
    assign wdata_a = '0;
    assign wmask_a = 2'b11;
    assign wmask_b = 2'b11;   // Word accesses only

    fetch_stage fetch_i (
        .clk           (clk),
        .rst           (rst),
        .hold          (stall),
        .resp_a        (resp_a),
        .rdata_a       (rdata_a),
        .branch_taken  (branch_taken),
        .branch_target (ex_mem.addr),
        .read_a        (read_a),
        .address_a     (address_a),
        .stall_fetch   (stall_fetch),
        .if_out        (if_out)
    );

    decode_stage decode_i (
        .clk     (clk),
        .rst     (rst),
        .id_in   (if_id),
        .wb_load (wb_load),
        .wb_dest (wb_dest),
        .wb_data (wb_data),
        .id_out  (id_out)
    );

    execute_stage execute_i (
        .ex_in  (id_ex),
        .ex_out (ex_out)
    );

    mem_stage mem_i (
        .clk          (clk),
        .rst          (rst),
        .mem_in       (ex_mem),
        .resp_b       (resp_b),
        .rdata_b      (rdata_b),
        .read_b       (read_b),
        .write_b      (write_b),
        .address_b    (address_b),
        .wdata_b      (wdata_b),
        .stall_mem    (stall_mem),
        .branch_taken (branch_taken),
        .wb_load      (wb_load),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
        end else if (!stall) begin
            if_id  <= if_out;
            id_ex  <= id_out;
            ex_mem <= ex_out;
        end else if (mem_done) begin
            // Retire the access so it is neither repeated nor written back twice
            ex_mem.ctrl.mem_read     <= 1'b0;
            ex_mem.ctrl.mem_write    <= 1'b0;
            ex_mem.ctrl.load_regfile <= 1'b0;
            ex_mem.ctrl.set_cc       <= 1'b0;
        end
    end

endmodule : cpu_datapath

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        forever #4 clk = ~clk;
    end

    // Reset for five rising edges, changed just after an edge
    task automatic pulse_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    endtask

endmodule : tb_clock

//--- tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic        clk,
    input  logic        rst,
    input  logic        read_a,
    input  logic [15:0] address_a,
    output logic        resp_a,
    output logic [15:0] rdata_a,
    input  logic        read_b,
    input  logic        write_b,
    input  logic [15:0] address_b,
    input  logic [15:0] wdata_b,
    output logic        resp_b,
    output logic [15:0] rdata_b
);

    logic [15:0] mem [32768];
    logic [31:0] write_log [$];     // {address, data} of each port B write
    logic        fixed_latency = 1'b0;
    int          wait_a = 0;        // Cycles left until resp, 0 when idle
    int          wait_b = 0;

    initial begin
        resp_a  = 1'b0;
        rdata_a = '0;
        resp_b  = 1'b0;
        rdata_b = '0;
    end

    function automatic int draw_latency();
        return fixed_latency ? 1 : 1 + int'($urandom % 4);
    endfunction

    function automatic int log_count();
        return write_log.size();
    endfunction

    function automatic logic [31:0] log_entry(input int idx);
        return write_log[idx];
    endfunction

    task automatic write_word(input int index, input logic [15:0] value);
        mem[index] = value;
    endtask

    task automatic fill_pattern();
        for (int i = 0; i < 32768; i++)
            mem[i] = 16'(i * 40503) ^ 16'h5a5a;  // Odd multiplier keeps every address bit
    endtask

    always @(posedge clk) begin
        #1;
        resp_a <= 1'b0;
        if (rst || !read_a) begin
            wait_a = 0;
        end else begin
            if (wait_a == 0)
                wait_a = draw_latency();
            wait_a--;
            if (wait_a == 0) begin
                resp_a  <= 1'b1;
                rdata_a <= mem[address_a[15:1]];
            end
        end
    end

    always @(posedge clk) begin
        #1;
        resp_b <= 1'b0;
        if (rst) begin
            wait_b = 0;
            write_log.delete();
        end else if (!(read_b || write_b)) begin
            wait_b = 0;
        end else begin
            if (wait_b == 0)
                wait_b = draw_latency();
            wait_b--;
            if (wait_b == 0) begin
                resp_b <= 1'b1;
                if (write_b) begin
                    mem[address_b[15:1]] = wdata_b;
                    write_log.push_back({address_b, wdata_b});
                end else begin
                    rdata_b <= mem[address_b[15:1]];
                end
            end
        end
    end

endmodule : tb_memory

//--- cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    logic        clk;
    logic        rst;
    logic        resp_a, read_a, write_a, resp_b, read_b, write_b;
    logic [1:0]  wmask_a, wmask_b;
    logic [15:0] rdata_a, address_a, wdata_a, rdata_b, address_b, wdata_b;

    logic [15:0] prog [$];
    logic [15:0] ld_val;
    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    tb_clock clk_i (.*);
    tb_memory mem_i (.*);
    cpu_datapath dut_i (.*);

    function automatic logic [15:0] enc(input logic [3:0] op, input logic [2:0] a,
                                        input logic [2:0] b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic nops(input int n);
        repeat (n) prog.push_back(16'h0000);
    endtask

    task automatic start_program();
        prog.push_back(enc(4'h0, 3'b111, 3'b111, 6'h3f));  // BRnzp to itself
        nops(3);
        fork
            clk_i.pulse_reset();
            begin
                repeat (2) @(posedge clk);
                #2;
                mem_i.fill_pattern();
                for (int i = 0; i < prog.size(); i++)
                    mem_i.write_word(i, prog[i]);
                mem_i.write_word(16'hffc8 >> 1, ld_val);  // LDR source word
            end
        join
        prog.delete();
    endtask

    task automatic wait_writes(input int n);
        int cycles;
        cycles = 0;
        while (mem_i.log_count() < n && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (mem_i.log_count() < n) begin
            $display("timeout: only %0d of %0d port B writes seen", mem_i.log_count(), n);
            errors++;
        end
    endtask

    task automatic check_write(input int idx, input logic [15:0] addr, input logic [15:0] data);
        logic [31:0] entry;
        entry = mem_i.log_entry(idx);
        check_value("address_b", entry[31:16], addr);
        check_value("wdata_b", entry[15:0], data);
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic build_alu_program();
        prog.push_back(enc(4'h1, 3'd1, 3'd0, 6'b100111));  // R1 = 7
        prog.push_back(enc(4'h1, 3'd2, 3'd0, 6'b111101));  // R2 = -3
        nops(2);
        prog.push_back(enc(4'h1, 3'd3, 3'd1, 6'd2));       // R3 = R1 + R2
        prog.push_back(enc(4'h5, 3'd4, 3'd1, 6'b111110));  // R4 = R1 & -2
        prog.push_back(enc(4'h9, 3'd5, 3'd2, 6'h3f));      // R5 = ~R2
        prog.push_back(enc(4'h5, 3'd6, 3'd1, 6'd2));       // R6 = R1 & R2
        prog.push_back(enc(4'h1, 3'd7, 3'd2, 6'b100101));  // R7 = R2 + 5
        prog.push_back(enc(4'h5, 3'd1, 3'd2, 6'b101100));  // R1 = R2 & 12
        nops(2);
        for (int r = 3; r <= 7; r++)
            prog.push_back(enc(4'h7, 3'(r), 3'd0, 6'(2 - r)));
        prog.push_back(enc(4'h7, 3'd1, 3'd0, 6'b111010));  // STR R1 at -6
    endtask

    task automatic compare_alu_log();
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] want [6];
        r1 = 16'd7;
        r2 = -16'd3;
        want[0] = r1 + r2;
        want[1] = r1 & 16'hfffe;
        want[2] = ~r2;
        want[3] = r1 & r2;
        want[4] = r2 + 16'd5;
        want[5] = r2 & 16'd12;
        for (int i = 0; i < 6; i++)
            check_write(i, 16'h0000 - 16'(2 * (i + 1)), want[i]);
    endtask

    task automatic test_reset();
        int e0;
        int cycles;
        e0 = errors;
        cycles = 0;
        nops(4);
        start_program();
        while (read_a !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            check_value("read_b", {15'b0, read_b}, 16'h0);
            check_value("write_b", {15'b0, write_b}, 16'h0);
            cycles++;
        end
        if (read_a !== 1'b1) begin
            $display("no port A read started after reset");
            errors++;
        end
        check_value("address_a", address_a, 16'h0000);
        check_value("write_a", {15'b0, write_a}, 16'h0);
        check_value("wdata_a", wdata_a, 16'h0000);
        check_value("wmask_a", {14'b0, wmask_a}, 16'h0003);
        check_value("wmask_b", {14'b0, wmask_b}, 16'h0003);
        report("test_reset", e0);
    endtask

    task automatic test_alu();
        int e0;
        e0 = errors;
        build_alu_program();
        start_program();
        wait_writes(6);
        compare_alu_log();
        report("test_alu", e0);
    endtask

    task automatic test_load_store();
        int e0;
        logic [15:0] base;
        e0 = errors;
        prog.push_back(enc(4'h1, 3'd1, 3'd0, 6'b110000));  // R1 = -16
        nops(2);
        prog.push_back(enc(4'h6, 3'd2, 3'd1, 6'b101100));  // LDR R2, R1, #-20
        nops(2);
        prog.push_back(enc(4'h1, 3'd3, 3'd2, 6'b100001));  // R3 = R2 + 1
        prog.push_back(enc(4'h7, 3'd2, 3'd1, 6'd3));       // STR R2, R1, #3
        nops(1);
        prog.push_back(enc(4'h7, 3'd3, 3'd1, 6'b111110));  // STR R3, R1, #-2
        start_program();
        wait_writes(2);
        base = 16'h0000 - 16'd16;
        check_write(0, base + 16'd6, ld_val);
        check_write(1, base - 16'd4, ld_val + 16'd1);
        report("test_load_store", e0);
    endtask

    task automatic test_branch();
        int e0;
        e0 = errors;
        prog.push_back(enc(4'h1, 3'd2, 3'd0, 6'b100001));  // Markers 1, 2, 3
        prog.push_back(enc(4'h1, 3'd3, 3'd0, 6'b100010));
        prog.push_back(enc(4'h1, 3'd4, 3'd0, 6'b100011));
        prog.push_back(enc(4'h1, 3'd1, 3'd0, 6'b111111));  // R1 = -1 sets cc negative
        nops(2);
        prog.push_back(enc(4'h0, 3'b011, 3'd0, 6'd4));     // BRzp falls through
        nops(3);
        prog.push_back(enc(4'h7, 3'd2, 3'd0, 6'h3f));
        prog.push_back(enc(4'h0, 3'b100, 3'd0, 6'd4));     // BRn skips one store
        nops(3);
        prog.push_back(enc(4'h7, 3'd3, 3'd0, 6'h3e));
        prog.push_back(enc(4'h7, 3'd4, 3'd0, 6'h3d));
        start_program();
        wait_writes(2);
        check_write(0, 16'hfffe, 16'd1);
        check_write(1, 16'hfffa, 16'd3);
        report("test_branch", e0);
    endtask

    task automatic test_latency();
        int e0;
        e0 = errors;
        mem_i.fixed_latency = 1'b1;
        build_alu_program();
        start_program();
        wait_writes(6);
        compare_alu_log();
        mem_i.fixed_latency = 1'b0;
        build_alu_program();
        start_program();
        wait_writes(6);
        compare_alu_log();
        report("test_latency", e0);
    endtask

    initial begin
        ld_val = 16'($urandom(32'h36ff));
        test_reset();
        test_alu();
        test_load_store();
        test_branch();
        test_latency();
        $display("summary: %0d ok, %0d with errors", n_pass, n_fail);
        if (n_fail == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule : cpu_tb

//--- src.f
lc3b_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
cpu_datapath.sv
tb_clock.sv
tb_memory.sv
cpu_tb.sv
